// File: include/xgmii_tx_params.svh
`ifndef XGMII_TX_PARAMS_SVH
`define XGMII_TX_PARAMS_SVH

// ------------------------------
// Payload queues
// ------------------------------
`define TX_FIFO_DEPTH 8

// Words of payload in every frame
`define PAYLOAD_WORDS 2

// ------------------------------
// Frame pacing and UDP fields
// ------------------------------
`define IFG_WORDS 1

`define UDP_PORT_BASE 16'h0bb8  // Channel 1 uses base plus one

`define MAGIC_CODE 32'h5a5a_c3c3

`endif

// File: design/xgmii_tx_pkg.sv
package xgmii_tx_pkg;

	// One transmit lane word, control bits above eight data bytes
	typedef struct packed {
		logic [7:0]  ctrl;
		logic [63:0] data;
	} xgmii_lane_t;

	typedef logic [0:0] chan_t;  // Payload channel index

	// ------------------------------
	// XGMII control encodings
	// ------------------------------
	localparam xgmii_lane_t XGMII_IDLE_WORD = '{ctrl: 8'hff, data: 64'h0707_0707_0707_0707};
	localparam xgmii_lane_t XGMII_START_WORD = '{ctrl: 8'h01, data: 64'hd555_5555_5555_55fb};
	localparam logic [7:0] XGMII_TERM_CTRL = 8'hf0;  // FCS in lanes 0..3
	localparam logic [7:0] XGMII_TERM_BYTE = 8'hfd;
	localparam logic [7:0] XGMII_IDLE_BYTE = 8'h07;

	// ------------------------------
	// Protocol header constants
	// ------------------------------
	localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
	localparam logic [7:0]  IPV4_VER_IHL   = 8'h45;  // Version 4, 20 byte header
	localparam logic [7:0]  IPV4_TTL       = 8'h40;
	localparam logic [7:0]  IPV4_PROTO_UDP = 8'h11;
	localparam logic [15:0] UDP_SRC_PORT   = 16'h0d5e;

endpackage

// File: design/payload_if.sv
interface payload_if;

	logic        frame_ready;    // Whole frame of payload available
	logic [63:0] word;           // Head of queue
	logic        take;           // Pop one word
	logic        overflow_seen;  // Sticky, push into a full queue

	modport fifo_side (output frame_ready, output word, output overflow_seen, input take);

	modport arb_side (input frame_ready, input word, input overflow_seen, output take);

endinterface

// File: design/payload_fifo.sv
`include "xgmii_tx_params.svh"

module payload_fifo #(
	parameter int DEPTH = `TX_FIFO_DEPTH
) (
	input  logic         xgmii_clk,
	input  logic         sys_rst,
	input  logic         push,
	input  logic [63:0]  push_data,
	payload_if.fifo_side q
);

	localparam int AW = $clog2(DEPTH);
	localparam logic [AW:0] FULL_CNT  = (AW+1)'(DEPTH);
	localparam logic [AW:0] FRAME_CNT = (AW+1)'(`PAYLOAD_WORDS);

	logic [63:0]   mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          full;
	logic          empty;
	logic          wr_en;
	logic          rd_en;

	assign full  = (count == FULL_CNT);
	assign empty = (count == '0);
	assign wr_en = push && !full;     // Word dropped on overflow
	assign rd_en = q.take && !empty;

	always_ff @(posedge xgmii_clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge xgmii_clk) begin
		if (sys_rst) begin
			wr_ptr          <= '0;
			rd_ptr          <= '0;
			count           <= '0;
			q.overflow_seen <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;  // Wraps at power-of-two depth
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			if (push && full) begin
				q.overflow_seen <= 1'b1;
			end
		end
	end

	assign q.word        = mem[rd_ptr];
	assign q.frame_ready = (count >= FRAME_CNT);

	// Sources have no back-pressure, so the queue must never fill
	a_no_overflow: assert property (@(posedge xgmii_clk) disable iff (sys_rst)
		!q.overflow_seen);

	// Builder only pops words that the arbiter saw as ready
	a_no_underflow: assert property (@(posedge xgmii_clk) disable iff (sys_rst)
		q.take |-> !empty);

endmodule

// File: design/tx_arbiter.sv
module tx_arbiter (
	input  logic                xgmii_clk,
	input  logic                sys_rst,
	payload_if.arb_side         ch0,
	payload_if.arb_side         ch1,
	payload_if.fifo_side        sel,
	input  logic                busy,
	output xgmii_tx_pkg::chan_t grant
);

	xgmii_tx_pkg::chan_t last;    // Channel of the frame served most recently
	logic                active;  // Grant offered, frame not yet started
	logic [1:0]          ready;

	assign ready = {ch1.frame_ready, ch0.frame_ready};

	// ------------------------------
	// Round-robin grant
	// ------------------------------
	always_ff @(posedge xgmii_clk) begin
		if (sys_rst) begin
			grant  <= 1'b0;
			last   <= 1'b1;  // Channel 0 wins the first tie
			active <= 1'b0;
		end else if (busy) begin
			active <= 1'b0;  // Frame under way, grant frozen
			last   <= grant;
		end else if (!active) begin
			if (ready[~last]) begin
				grant  <= ~last;
				active <= 1'b1;
			end else if (ready[last]) begin
				grant  <= last;
				active <= 1'b1;
			end
		end
	end

	// ------------------------------
	// Routing to the builder
	// ------------------------------
	assign sel.word        = (grant == 1'b1) ? ch1.word : ch0.word;
	assign sel.frame_ready = active && ready[grant];
	assign ch0.take        = sel.take && (grant == 1'b0);
	assign ch1.take        = sel.take && (grant == 1'b1);

	// Payload of one frame must come from one queue
	a_take_in_frame: assert property (@(posedge xgmii_clk) disable iff (sys_rst)
		sel.take |-> busy);

endmodule

// File: design/crc32_d64.sv
module crc32_d64 (
	input  logic        xgmii_clk,
	input  logic        restart,
	input  logic        en,
	input  logic [63:0] data,
	output logic [31:0] crc
);

	localparam logic [31:0] POLY = 32'h04c1_1db7;  // Ethernet CRC-32

	// Eight bytes per step, byte 0 first, each byte LSB first as on the wire
	function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [63:0] d);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 64; i++) begin
			if (r[31] ^ d[i]) begin
				r = {r[30:0], 1'b0} ^ POLY;
			end else begin
				r = {r[30:0], 1'b0};
			end
		end
		return r;
	endfunction

	always_ff @(posedge xgmii_clk) begin
		if (restart) begin
			crc <= 32'hffff_ffff;  // Preset to all ones
		end else if (en) begin
			crc <= crc_step(crc, data);
		end
	end

endmodule

// File: design/udp_frame_tx.sv
`include "xgmii_tx_params.svh"

module udp_frame_tx (
	input  logic                      xgmii_clk,
	input  logic                      sys_rst,
	payload_if.arb_side               pl,
	input  xgmii_tx_pkg::chan_t       chan,
	output logic                      busy,
	input  logic [31:0]               if_v4addr,
	input  logic [47:0]               if_macaddr,
	input  logic [31:0]               dest_v4addr,
	input  logic [47:0]               dest_macaddr,
	output xgmii_tx_pkg::xgmii_lane_t xgmii_txd
);

	localparam int TERM_POS = 7 + `PAYLOAD_WORDS;  // Start, six header words, payload
	localparam int CW = $clog2(TERM_POS + 1);
	localparam int GW = $clog2(`IFG_WORDS + 2);
	localparam logic [CW-1:0] PAY_IDX  = CW'(7);
	localparam logic [CW-1:0] TERM_IDX = CW'(TERM_POS);
	localparam logic [15:0] IP_LEN  = 16'(34 + 8 * `PAYLOAD_WORDS);  // IP+UDP+magic+pad
	localparam logic [15:0] UDP_LEN = 16'(14 + 8 * `PAYLOAD_WORDS);
	localparam logic [31:0] MAGIC   = `MAGIC_CODE;

	typedef enum logic [1:0] {ST_IDLE, ST_SEND, ST_GAP} state_t;

	state_t                    state;
	logic [CW-1:0]             cnt;
	logic [GW-1:0]             gap_cnt;
	xgmii_tx_pkg::xgmii_lane_t lane_next;
	logic                      crc_restart;
	logic                      crc_en;
	logic [31:0]               crc_reg;
	logic [31:0]               fcs;
	logic [47:0]               dst_mac_n;
	logic [47:0]               src_mac_n;
	logic [31:0]               src_ip_n;
	logic [31:0]               dst_ip_n;
	logic [31:0]               magic_n;
	logic [15:0]               dst_port;
	logic [15:0]               dst_port_n;
	logic [15:0]               src_port_n;
	logic [15:0]               ethertype_n;
	logic [15:0]               ip_len_n;
	logic [15:0]               udp_len_n;
	logic [15:0]               ip_csum;
	logic [15:0]               csum_n;
	logic [19:0]               csum_raw;
	logic [16:0]               csum_fold;

	// ------------------------------
	// Header fields in lane byte order
	// ------------------------------
	assign dst_port    = `UDP_PORT_BASE + 16'(chan);
	assign dst_mac_n   = {<<8{dest_macaddr}};  // Network byte 0 in lane 0
	assign src_mac_n   = {<<8{if_macaddr}};
	assign src_ip_n    = {<<8{if_v4addr}};
	assign dst_ip_n    = {<<8{dest_v4addr}};
	assign magic_n     = {<<8{MAGIC}};
	assign dst_port_n  = {<<8{dst_port}};
	assign src_port_n  = {<<8{xgmii_tx_pkg::UDP_SRC_PORT}};
	assign ethertype_n = {<<8{xgmii_tx_pkg::ETHERTYPE_IPV4}};
	assign ip_len_n    = {<<8{IP_LEN}};
	assign udp_len_n   = {<<8{UDP_LEN}};
	assign csum_n      = {<<8{ip_csum}};

	// IPv4 header checksum, identification and fragment fields are zero
	assign csum_raw  = 20'({xgmii_tx_pkg::IPV4_VER_IHL, 8'h00}) + 20'(IP_LEN)
		+ 20'({xgmii_tx_pkg::IPV4_TTL, xgmii_tx_pkg::IPV4_PROTO_UDP})
		+ 20'(if_v4addr[31:16]) + 20'(if_v4addr[15:0])
		+ 20'(dest_v4addr[31:16]) + 20'(dest_v4addr[15:0]);
	assign csum_fold = 17'(csum_raw[15:0]) + 17'(csum_raw[19:16]);
	assign ip_csum   = ~(csum_fold[15:0] + 16'(csum_fold[16]));

	assign fcs = ~32'({<<{crc_reg}});  // Reflected and complemented

	// ------------------------------
	// Next lane word
	// ------------------------------
	always_comb begin
		lane_next = xgmii_tx_pkg::XGMII_IDLE_WORD;
		if (state == ST_SEND) begin
			case (cnt)
				CW'(0):   lane_next = xgmii_tx_pkg::XGMII_START_WORD;
				CW'(1):   lane_next = {8'h00, src_mac_n[15:0], dst_mac_n};
				CW'(2):   lane_next = {8'h00, 8'h00, xgmii_tx_pkg::IPV4_VER_IHL, ethertype_n,
					src_mac_n[47:16]};
				CW'(3):   lane_next = {8'h00, xgmii_tx_pkg::IPV4_PROTO_UDP,
					xgmii_tx_pkg::IPV4_TTL, 16'h0000, 16'h0000, ip_len_n};
				CW'(4):   lane_next = {8'h00, dst_ip_n[15:0], src_ip_n, csum_n};
				CW'(5):   lane_next = {8'h00, udp_len_n, dst_port_n, src_port_n, dst_ip_n[31:16]};
				CW'(6):   lane_next = {8'h00, 16'h0000, magic_n, 16'h0000};  // UDP csum zero
				TERM_IDX: lane_next = {xgmii_tx_pkg::XGMII_TERM_CTRL,
					{3{xgmii_tx_pkg::XGMII_IDLE_BYTE}}, xgmii_tx_pkg::XGMII_TERM_BYTE, fcs};
				default:  lane_next = {8'h00, pl.word};  // Payload
			endcase
		end
	end

	assign pl.take     = (state == ST_SEND) && (cnt >= PAY_IDX) && (cnt < TERM_IDX);
	assign crc_restart = (state == ST_SEND) && (cnt == '0);
	assign crc_en      = (state == ST_SEND) && (cnt != '0) && (cnt < TERM_IDX);
	assign busy        = (state != ST_IDLE);

	crc32_d64 u_crc (
		.xgmii_clk (xgmii_clk),
		.restart   (crc_restart),
		.en        (crc_en),
		.data      (lane_next.data),
		.crc       (crc_reg)
	);

	// ------------------------------
	// Frame sequencer
	// ------------------------------
	always_ff @(posedge xgmii_clk) begin
		if (sys_rst) begin
			state     <= ST_IDLE;
			cnt       <= '0;
			gap_cnt   <= '0;
			xgmii_txd <= xgmii_tx_pkg::XGMII_IDLE_WORD;
		end else begin
			xgmii_txd <= lane_next;
			case (state)
				ST_IDLE: begin
					if (pl.frame_ready) begin
						state <= ST_SEND;
					end
				end
				ST_SEND: begin
					if (cnt == TERM_IDX) begin
						cnt <= '0;
						if (`IFG_WORDS == 0) begin
							state <= ST_IDLE;
						end else begin
							state   <= ST_GAP;
							gap_cnt <= GW'(`IFG_WORDS - 1);
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_GAP: begin
					gap_cnt <= gap_cnt - 1'b1;
					if (gap_cnt == '0) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Grant, and with it the UDP port and payload queue, fixed for the whole frame
	a_chan_hold: assert property (@(posedge xgmii_clk) disable iff (sys_rst)
		busy |=> $stable(chan));

endmodule

// File: design/xgmii_tx_top.sv
module xgmii_tx_top (
	input  logic        xgmii_clk,
	input  logic        sys_rst,
	input  logic        ch0_push,
	input  logic [63:0] ch0_data,
	input  logic        ch1_push,
	input  logic [63:0] ch1_data,
	input  logic [31:0] if_v4addr,
	input  logic [47:0] if_macaddr,
	input  logic [31:0] dest_v4addr,
	input  logic [47:0] dest_macaddr,
	output logic [71:0] xgmii_txd
);

	payload_if q0 ();
	payload_if q1 ();
	payload_if q_sel ();  // Granted queue toward the builder

	xgmii_tx_pkg::chan_t grant;
	logic                busy;

	payload_fifo u_fifo0 (
		.xgmii_clk (xgmii_clk),
		.sys_rst   (sys_rst),
		.push      (ch0_push),
		.push_data (ch0_data),
		.q         (q0)
	);

	payload_fifo u_fifo1 (
		.xgmii_clk (xgmii_clk),
		.sys_rst   (sys_rst),
		.push      (ch1_push),
		.push_data (ch1_data),
		.q         (q1)
	);

	tx_arbiter u_arb (
		.xgmii_clk (xgmii_clk),
		.sys_rst   (sys_rst),
		.ch0       (q0),
		.ch1       (q1),
		.sel       (q_sel),
		.busy      (busy),
		.grant     (grant)
	);

	udp_frame_tx u_frame_tx (
		.xgmii_clk    (xgmii_clk),
		.sys_rst      (sys_rst),
		.pl           (q_sel),
		.chan         (grant),
		.busy         (busy),
		.if_v4addr    (if_v4addr),
		.if_macaddr   (if_macaddr),
		.dest_v4addr  (dest_v4addr),
		.dest_macaddr (dest_macaddr),
		.xgmii_txd    (xgmii_txd)
	);

endmodule

// File: testbench/tb_xgmii_tx.sv
`include "xgmii_tx_params.svh"

module tb_xgmii_tx;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int    FRAME_LEN    = 8 + `PAYLOAD_WORDS;  // Start, six headers, payload, terminate
	localparam int    MAX_FRAMES   = 8;
	localparam int    RESET_CYCLES = 4;
	localparam string GOLDEN_FILE  = "testbench/xgmii_tx_golden.txt";

	logic        xgmii_clk;
	logic        sys_rst;
	logic        ch0_push;
	logic [63:0] ch0_data;
	logic        ch1_push;
	logic [63:0] ch1_data;
	logic [31:0] if_v4addr;
	logic [47:0] if_macaddr;
	logic [31:0] dest_v4addr;
	logic [47:0] dest_macaddr;
	logic [71:0] xgmii_txd;

	// ------------------------------
	// Golden contents
	// ------------------------------
	logic [47:0] gold_if_mac;
	logic [31:0] gold_if_ip;
	logic [47:0] gold_dest_mac;
	logic [31:0] gold_dest_ip;
	logic [71:0] hdr_words [1:6];
	logic [71:0] exp_words [MAX_FRAMES][FRAME_LEN];
	int          push_cycle [$];
	int          push_chan [$];
	logic [63:0] push_word [$];
	logic [71:0] f_w5 [$];
	logic [71:0] f_p0 [$];
	logic [71:0] f_p1 [$];
	int          num_frames = 0;

	int cycle        = 0;
	int cycle_limit  = 200;
	int value_errors = 0;
	int other_errors = 0;
	int frames_seen  = 0;
	int word_idx     = 0;
	int idle_run     = 0;
	bit in_frame     = 1'b0;

	xgmii_tx_top u_xgmii_tx_top (
		.xgmii_clk    (xgmii_clk),
		.sys_rst      (sys_rst),
		.ch0_push     (ch0_push),
		.ch0_data     (ch0_data),
		.ch1_push     (ch1_push),
		.ch1_data     (ch1_data),
		.if_v4addr    (if_v4addr),
		.if_macaddr   (if_macaddr),
		.dest_v4addr  (dest_v4addr),
		.dest_macaddr (dest_macaddr),
		.xgmii_txd    (xgmii_txd)
	);

	initial begin
		xgmii_clk = 1'b0;
		forever #20 xgmii_clk = ~xgmii_clk;
	end

	always @(posedge xgmii_clk) begin
		cycle <= cycle + 1;
	end

	task automatic compare_word(input string name, input logic [71:0] got, input logic [71:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got %h expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic report_bad_line(input string line);
		$display("Golden file line could not be parsed: %s", line);
		other_errors++;
	endtask

	// Reflected byte-wise CRC-32 over destination MAC through last payload byte
	function automatic logic [31:0] ethernet_fcs(input int f);
		logic [31:0] c;
		c = 32'hffff_ffff;
		for (int w = 1; w < FRAME_LEN - 1; w++) begin
			for (int k = 0; k < 8; k++) begin
				c = c ^ {24'h0, exp_words[f][w][8*k +: 8]};
				for (int j = 0; j < 8; j++) begin
					c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
				end
			end
		end
		return ~c;
	endfunction

	task automatic load_golden();
		int          fd;
		int          n;
		int          cyc;
		int          ch;
		int          idx;
		string       line;
		logic [63:0] data;
		logic [71:0] w0;
		logic [71:0] w1;
		logic [71:0] w2;
		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open golden file %s", GOLDEN_FILE);
			other_errors++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0) begin
				case (line[0])
					"A": if ($sscanf(line, "A %h %h %h %h", gold_if_mac, gold_if_ip,
							gold_dest_mac, gold_dest_ip) != 4) report_bad_line(line);
					"P": begin
						if ($sscanf(line, "P %d %d %h", cyc, ch, data) != 3) begin
							report_bad_line(line);
						end else begin
							push_cycle.push_back(cyc);
							push_chan.push_back(ch);
							push_word.push_back(data);
						end
					end
					"H": begin
						if ($sscanf(line, "H %d %h", idx, w0) != 2 || idx < 1 || idx > 6) begin
							report_bad_line(line);
						end else begin
							hdr_words[idx] = w0;
						end
					end
					"F": begin
						if ($sscanf(line, "F %h %h %h", w0, w1, w2) != 3) begin
							report_bad_line(line);
						end else begin
							f_w5.push_back(w0);
							f_p0.push_back(w1);
							f_p1.push_back(w2);
						end
					end
					default: ;  // Comment or blank line
				endcase
			end
		end
		$fclose(fd);
		num_frames = (f_w5.size() > MAX_FRAMES) ? MAX_FRAMES : f_w5.size();
		for (int f = 0; f < num_frames; f++) begin
			exp_words[f][0] = xgmii_tx_pkg::XGMII_START_WORD;
			for (int w = 1; w <= 6; w++) begin
				exp_words[f][w] = hdr_words[w];
			end
			exp_words[f][5] = f_w5[f];  // Carries the UDP port of the channel
			exp_words[f][7] = f_p0[f];
			exp_words[f][8] = f_p1[f];
			exp_words[f][FRAME_LEN-1] = {xgmii_tx_pkg::XGMII_TERM_CTRL,
				{3{xgmii_tx_pkg::XGMII_IDLE_BYTE}}, xgmii_tx_pkg::XGMII_TERM_BYTE, ethernet_fcs(f)};
		end
	endtask

	// ------------------------------
	// Output capture and checks
	// ------------------------------
	always @(negedge xgmii_clk) begin
		if (cycle > RESET_CYCLES) begin
			if (in_frame) begin
				compare_word($sformatf("xgmii_txd frame %0d word %0d", frames_seen, word_idx),
					xgmii_txd, exp_words[frames_seen][word_idx]);
				word_idx++;
				if (word_idx == FRAME_LEN) begin
					in_frame = 1'b0;
					frames_seen++;
					idle_run = 0;
				end
			end else if (xgmii_txd === xgmii_tx_pkg::XGMII_START_WORD) begin
				if (frames_seen >= num_frames) begin
					$display("More frames appeared on xgmii_txd than the golden file lists");
					other_errors++;
				end else begin
					if (frames_seen > 0 && idle_run < `IFG_WORDS) begin
						$display("Only %0d idle words before frame %0d", idle_run, frames_seen);
						other_errors++;
					end
					in_frame = 1'b1;
					word_idx = 1;  // Start word already matched
				end
			end else begin
				compare_word("xgmii_txd between frames", xgmii_txd,
					xgmii_tx_pkg::XGMII_IDLE_WORD);
				idle_run++;
			end
		end
	end

	// ------------------------------
	// Stimulus and run control
	// ------------------------------
	initial begin
		sys_rst      = 1'b1;
		ch0_push     = 1'b0;
		ch0_data     = '0;
		ch1_push     = 1'b0;
		ch1_data     = '0;
		if_v4addr    = '0;
		if_macaddr   = '0;
		dest_v4addr  = '0;
		dest_macaddr = '0;
		load_golden();
		if (num_frames == 0) begin
			$display("Golden file lists no expected frames");
			other_errors++;
		end
		cycle_limit = 20 * num_frames * FRAME_LEN + 200;
		@(negedge xgmii_clk);
		if_v4addr    = gold_if_ip;
		if_macaddr   = gold_if_mac;
		dest_v4addr  = gold_dest_ip;
		dest_macaddr = gold_dest_mac;
		while (cycle < RESET_CYCLES) @(negedge xgmii_clk);
		sys_rst = 1'b0;
		for (int i = 0; i < push_cycle.size(); i++) begin
			while (cycle < push_cycle[i] && cycle < cycle_limit) begin
				@(negedge xgmii_clk);
				ch0_push = 1'b0;
				ch1_push = 1'b0;
			end
			if (push_chan[i] == 0) begin
				ch0_push = 1'b1;
				ch0_data = push_word[i];
			end else begin
				ch1_push = 1'b1;
				ch1_data = push_word[i];
			end
		end
		@(negedge xgmii_clk);
		ch0_push = 1'b0;
		ch1_push = 1'b0;
		while (frames_seen < num_frames && cycle < cycle_limit) @(posedge xgmii_clk);
		if (frames_seen < num_frames) begin
			$display("Timeout after %0d cycles with %0d of %0d frames seen",
				cycle, frames_seen, num_frames);
			other_errors++;
		end else begin
			repeat (FRAME_LEN) @(posedge xgmii_clk);  // Trailing idles are checked too
		end
		$display("Errors: %0d mismatched values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: sim.f
+incdir+include
design/xgmii_tx_pkg.sv
design/payload_if.sv
design/payload_fifo.sv
design/tx_arbiter.sv
design/crc32_d64.sv
design/udp_frame_tx.sv
design/xgmii_tx_top.sv
testbench/tb_xgmii_tx.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the XGMII transmit testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_xgmii_tx \
	> "$LOG" 2>&1 \
	&& ./obj_dir/Vtb_xgmii_tx >> "$LOG" 2>&1 \
	|| echo "Build or simulation exited with an error, see $LOG"

# The log decides the result
grep -q "All tests passed!" "$LOG" && echo "PASS" || { echo "FAIL, see $LOG"; exit 1; }

// File: testbench/xgmii_tx_golden.txt
# A if_mac if_ip dest_mac dest_ip | P cycle chan data | H word_index lane_word
# F lane_word5 payload0 payload1, one F line per expected frame in output order
A 020000000001 c0a80001 020000000002 c0a80002
P 6 0 0123456789abcdef
P 7 0 fedcba9876543210
P 12 1 b0b0b0b0b0b0b0b0
P 13 1 b1b1b1b1b1b1b1b1
P 14 0 c0c0c0c0c0c0c0c0
P 15 0 c1c1c1c1c1c1c1c1
P 26 0 d0d0d0d0d0d0d0d0
P 27 0 d1d1d1d1d1d1d1d1
H 1 000002020000000002
H 2 000045000801000000
H 3 001140000000003200
H 4 00a8c00100a8c067f9
H 6 000000c3c35a5a0000
F 001e00b80b5e0d0200 000123456789abcdef 00fedcba9876543210
F 001e00b90b5e0d0200 00b0b0b0b0b0b0b0b0 00b1b1b1b1b1b1b1b1
F 001e00b80b5e0d0200 00c0c0c0c0c0c0c0c0 00c1c1c1c1c1c1c1c1
F 001e00b80b5e0d0200 00d0d0d0d0d0d0d0d0 00d1d1d1d1d1d1d1d1
